//--- vlog.f
+incdir+design
design/uop_pkg.sv
design/rs_pkg.sv
design/rs_entry.sv
design/int_rs_ordered.sv
design/int_prf.sv
design/fu_alu.sv
design/int_issue_top.sv
tb/int_issue_tb.sv

//--- Bender.yml
package:
  name: int_issue

export_include_dirs:
  - design

sources:
  - files:
      - design/uop_pkg.sv
      - design/rs_pkg.sv
      - design/rs_entry.sv
      - design/int_rs_ordered.sv
      - design/int_prf.sv
      - design/fu_alu.sv
      - design/int_issue_top.sv
  - target: test
    files:
      - tb/int_issue_tb.sv

//--- tb/int_issue_tb.sv
`default_nettype none

`include "int_rs_defs.svh"

module int_issue_tb
    import uop_pkg::*;
    import rs_pkg::*;
();

    localparam int WAIT_LIMIT = 200;
    localparam int ROB_SLOTS  = 1 << `ROB_IDX;

    typedef logic [`PHYS_IDX-1:0] preg_t;
    typedef logic [`ROB_IDX-1:0]  rob_t;

    logic          clk;
    logic          rst;
    logic          dispatch_valid;
    dispatch_uop_t dispatch_uop;
    logic          dispatch_ready;
    logic          result_valid;
    cdb_t          result;
    logic          result_ready;

    // reference model state, indexed by physical register or rob_id
    logic [`XLEN-1:0] shadow_prf  [`PHYS_REGS];
    logic [`XLEN-1:0] exp_value   [ROB_SLOTS];
    preg_t            exp_rd      [ROB_SLOTS];
    logic             exp_pending [ROB_SLOTS];
    rob_t             next_rob;
    rob_t             sent_q [$];
    rob_t             arrived_q [$];

    integer seed;
    int     errors;
    int     tests_run;
    int     test_start_errors;
    logic   hung;

    int_issue_top u_int_issue_top (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .result_valid   (result_valid),
        .result         (result),
        .result_ready   (result_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    function automatic logic [`XLEN-1:0] ref_alu(
        input fu_op_t           op,
        input logic [`XLEN-1:0] a,
        input logic [`XLEN-1:0] b
    );
        logic [`XLEN-1:0] r;
        case (op)
            op_add:  r = a + b;
            op_sub:  r = a - b;
            op_and:  r = a & b;
            op_or:   r = a | b;
            op_xor:  r = a ^ b;
            // only the low five bits of the amount count
            op_sll:  r = a << b[4:0];
            op_slt:  r = ($signed(a) < $signed(b)) ? 1 : 0;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic dispatch_uop_t make_uop(
        input fu_op_t           op,
        input preg_t            rd,
        input preg_t            rs1,
        input logic             rs1_valid,
        input preg_t            rs2,
        input logic             rs2_valid,
        input op2_sel_t         sel,
        input logic [`XLEN-1:0] imm
    );
        dispatch_uop_t u;
        u.rob_id    = next_rob;
        u.rs1_phy   = rs1;
        u.rs1_valid = rs1_valid;
        u.rs2_phy   = rs2;
        u.rs2_valid = rs2_valid;
        u.rd_phy    = rd;
        u.op2_sel   = sel;
        u.imm       = imm;
        u.fu_opcode = op;
        return u;
    endfunction

    // accepted uops are modelled in dispatch order
    task automatic record_uop(input dispatch_uop_t u);
        logic [`XLEN-1:0] b;
        b = (u.op2_sel == op2_imm) ? u.imm : shadow_prf[u.rs2_phy];
        exp_value[u.rob_id]   = ref_alu(u.fu_opcode, shadow_prf[u.rs1_phy], b);
        exp_rd[u.rob_id]      = u.rd_phy;
        exp_pending[u.rob_id] = 1'b1;
        if (u.rd_phy != '0) begin
            shadow_prf[u.rd_phy] = exp_value[u.rob_id];
        end
        sent_q.push_back(u.rob_id);
        next_rob = next_rob + 1'b1;
    endtask

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_result(input cdb_t got);
        if (!exp_pending[got.rob_id]) begin
            errors++;
            $display("Unexpected result at %0t: rob_id %0d was not outstanding",
                     $time, got.rob_id);
        end else begin
            if (got.rd_phy !== exp_rd[got.rob_id]) begin
                errors++;
                $display("Mismatch at %0t: rob_id %0d rd_phy %0d, expected %0d",
                         $time, got.rob_id, got.rd_phy, exp_rd[got.rob_id]);
            end
            if (got.value !== exp_value[got.rob_id]) begin
                errors++;
                $display("Mismatch at %0t: rob_id %0d value %h, expected %h",
                         $time, got.rob_id, got.value, exp_value[got.rob_id]);
            end
            exp_pending[got.rob_id] = 1'b0;
            arrived_q.push_back(got.rob_id);
        end
    endtask

    task automatic check_count(input int got, input int want, input string what);
        if (got != want) begin
            errors++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_stable(input logic valid_now, input cdb_t got, input cdb_t held);
        if (!valid_now) begin
            errors++;
            $display("result_valid dropped at %0t while result_ready was low", $time);
        end else if (got !== held) begin
            errors++;
            $display("Mismatch at %0t: stalled result changed from %h to %h", $time, held, got);
        end
    endtask

    task automatic check_order(input int pos, input rob_t got, input rob_t want);
        if (got !== want) begin
            errors++;
            $display("Mismatch at %0t: result %0d has rob_id %0d, expected %0d",
                     $time, pos, got, want);
        end
    endtask

    ////////////////////
    // drivers
    ////////////////////

    task automatic send_uop(
        input fu_op_t           op,
        input preg_t            rd,
        input preg_t            rs1,
        input logic             rs1_valid,
        input preg_t            rs2,
        input logic             rs2_valid,
        input op2_sel_t         sel,
        input logic [`XLEN-1:0] imm
    );
        dispatch_uop_t u;
        int            waited;
        logic          taken;
        u              = make_uop(op, rd, rs1, rs1_valid, rs2, rs2_valid, sel, imm);
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        taken          = 1'b0;
        waited         = 0;
        while (!taken && !hung) begin
            @(negedge clk);
            taken = dispatch_ready;
            @(posedge clk);
            #1;
            waited++;
            if (!taken && waited >= WAIT_LIMIT) begin
                errors++;
                hung = 1'b1;
                $display("Timeout at %0t: dispatch handshake for rob_id %0d never completed",
                         $time, u.rob_id);
            end
        end
        dispatch_valid = 1'b0;
        if (taken) begin
            record_uop(u);
        end
    endtask

    task automatic collect_results(input int count);
        int got;
        int waited;
        got          = 0;
        waited       = 0;
        result_ready = 1'b1;
        while (got < count && !hung) begin
            @(negedge clk);
            if (result_valid) begin
                check_result(result);
                got++;
                waited = 0;
            end else begin
                waited++;
            end
            @(posedge clk);
            #1;
            if (waited >= WAIT_LIMIT) begin
                errors++;
                hung = 1'b1;
                $display("Timeout at %0t: result handshake never completed, %0d of %0d seen",
                         $time, got, count);
            end
        end
        result_ready = 1'b0;
    endtask

    task automatic verify_arrival_order();
        for (int i = 0; i < sent_q.size() && i < arrived_q.size(); i++) begin
            check_order(i, arrived_q[i], sent_q[i]);
        end
    endtask

    task automatic begin_test();
        test_start_errors = errors;
        sent_q.delete();
        arrived_q.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        $display("%s: finished, %0d failed checks", name, errors - test_start_errors);
    endtask

    ////////////////////
    // tests
    ////////////////////

    task automatic run_imm_test();
        logic [`XLEN-1:0] imm;
        begin_test();
        for (int r = 1; r <= 4; r++) begin
            imm = $random(seed);
            // p3 negative and p4 positive for the signed compare
            if (r == 3) begin
                imm[`XLEN-1] = 1'b1;
            end
            if (r == 4) begin
                imm[`XLEN-1] = 1'b0;
            end
            send_uop(op_add, preg_t'(r), '0, 1'b1, '0, 1'b1, op2_imm, imm);
        end
        collect_results(4);
        end_test("imm_ops");
    endtask

    task automatic run_op_test();
        begin_test();
        send_uop(op_add, 5, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        send_uop(op_sub, 6, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        send_uop(op_and, 7, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        send_uop(op_or, 8, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        send_uop(op_xor, 9, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        send_uop(op_sll, 10, 1, 1'b1, 2, 1'b1, op2_reg, '0);
        // amount 0x25 shifts by 5
        send_uop(op_sll, 11, 1, 1'b1, 0, 1'b1, op2_imm, 32'h0000_0025);
        send_uop(op_slt, 12, 3, 1'b1, 4, 1'b1, op2_reg, '0);
        send_uop(op_slt, 13, 4, 1'b1, 3, 1'b1, op2_reg, '0);
        collect_results(9);
        end_test("alu_ops");
    endtask

    // results held back so consumers enter before their producer broadcasts
    task automatic run_chain_test();
        logic [`XLEN-1:0] imm;
        begin_test();
        imm = $random(seed);
        send_uop(op_add, 14, 1, 1'b1, 0, 1'b1, op2_imm, imm);
        send_uop(op_sub, 15, 14, 1'b0, 2, 1'b1, op2_reg, '0);
        send_uop(op_xor, 16, 15, 1'b0, 14, 1'b0, op2_reg, '0);
        collect_results(3);
        verify_arrival_order();
        end_test("dep_chain");
    endtask

    task automatic run_stall_test();
        dispatch_uop_t u;
        cdb_t          held;
        logic          held_seen;
        int            accepted;
        int            idle;
        int            rd;
        begin_test();
        accepted       = 0;
        idle           = 0;
        rd             = 17;
        held_seen      = 1'b0;
        result_ready   = 1'b0;
        u              = make_uop(op_add, preg_t'(rd), '0, 1'b1, '0, 1'b1, op2_imm, $random(seed));
        dispatch_valid = 1'b1;
        dispatch_uop   = u;
        while (idle < 20 && accepted <= `INTRS_DEPTH + 2) begin
            @(negedge clk);
            if (held_seen) begin
                check_stable(result_valid, result, held);
            end else if (result_valid) begin
                held      = result;
                held_seen = 1'b1;
            end
            if (dispatch_ready) begin
                record_uop(u);
                accepted++;
                idle = 0;
                rd++;
                u = make_uop(op_add, preg_t'(rd), '0, 1'b1, '0, 1'b1, op2_imm, $random(seed));
            end else begin
                idle++;
            end
            @(posedge clk);
            #1;
            dispatch_uop = u;
        end
        dispatch_valid = 1'b0;
        if (!held_seen) begin
            errors++;
            $display("result_valid never rose at %0t while results were stalled", $time);
        end
        check_count(accepted, `INTRS_DEPTH + 1, "accepted uops while stalled");
        collect_results(accepted);
        verify_arrival_order();
        end_test("stall_order");
    endtask

    initial begin
        seed           = 32'h124a;
        errors         = 0;
        tests_run      = 0;
        hung           = 1'b0;
        next_rob       = '0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_uop   = '0;
        result_ready   = 1'b0;
        for (int i = 0; i < `PHYS_REGS; i++) begin
            shadow_prf[i] = '0;
        end
        for (int i = 0; i < ROB_SLOTS; i++) begin
            exp_value[i]   = '0;
            exp_rd[i]      = '0;
            exp_pending[i] = 1'b0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        run_imm_test();
        if (!hung) begin
            run_op_test();
        end
        if (!hung) begin
            run_chain_test();
        end
        if (!hung) begin
            run_stall_test();
        end

        $display("tests run %0d, failed checks %0d", tests_run, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- design/int_issue_top.sv
`default_nettype none

`include "int_rs_defs.svh"

module int_issue_top
    import uop_pkg::*;
    import rs_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          dispatch_valid,
    input  dispatch_uop_t dispatch_uop,
    output logic          dispatch_ready,
    output logic          result_valid,
    output cdb_t          result,
    input  logic          result_ready
);

    logic                 cdb_valid;
    logic                 issue_valid;
    logic                 alu_ready;
    fu_alu_req_t          issue_req;
    logic [`PHYS_IDX-1:0] rs1_phy;
    logic [`PHYS_IDX-1:0] rs2_phy;
    logic [`XLEN-1:0]     rs1_value;
    logic [`XLEN-1:0]     rs2_value;

    // a completed result handshake is the cdb broadcast
    assign cdb_valid = result_valid && result_ready;

    int_rs_ordered u_int_rs_ordered (
        .clk            (clk),
        .rst            (rst),
        .dispatch_valid (dispatch_valid),
        .dispatch_uop   (dispatch_uop),
        .dispatch_ready (dispatch_ready),
        .issue_valid    (issue_valid),
        .issue_req      (issue_req),
        .alu_ready      (alu_ready),
        .cdb_valid      (cdb_valid),
        .cdb            (result),
        .rs1_phy        (rs1_phy),
        .rs2_phy        (rs2_phy),
        .rs1_value      (rs1_value),
        .rs2_value      (rs2_value)
    );

    int_prf u_int_prf (
        .clk       (clk),
        .rst       (rst),
        .rs1_phy   (rs1_phy),
        .rs2_phy   (rs2_phy),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .wr_en     (cdb_valid),
        .wr_phy    (result.rd_phy),
        .wr_value  (result.value)
    );

    fu_alu u_fu_alu (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issue_req    (issue_req),
        .alu_ready    (alu_ready),
        .result_valid (result_valid),
        .result       (result),
        .result_ready (result_ready)
    );

endmodule

`default_nettype wire

//--- design/fu_alu.sv
`default_nettype none

`include "int_rs_defs.svh"

module fu_alu
    import uop_pkg::*;
    import rs_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        issue_valid,
    input  fu_alu_req_t issue_req,
    output logic        alu_ready,
    output logic        result_valid,
    output cdb_t        result,
    input  logic        result_ready
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_out;
    logic             accept;

    assign op_a = issue_req.rs1_value;
    assign op_b = (issue_req.op2_sel == op2_imm) ? issue_req.imm : issue_req.rs2_value;

    always_comb begin
        case (issue_req.fu_opcode)
            op_add:  alu_out = op_a + op_b;
            op_sub:  alu_out = op_a - op_b;
            op_and:  alu_out = op_a & op_b;
            op_or:   alu_out = op_a | op_b;
            op_xor:  alu_out = op_a ^ op_b;
            op_sll:  alu_out = op_a << op_b[4:0];
            // signed compare, result is 0 or 1
            op_slt:  alu_out = {{(`XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_out = '0;
        endcase
    end

    // free, or the held result drains on this edge
    assign alu_ready = !result_valid || result_ready;
    assign accept    = issue_valid && alu_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (alu_ready) begin
            result_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            result.rob_id <= issue_req.rob_id;
            result.rd_phy <= issue_req.rd_phy;
            result.value  <= alu_out;
        end
    end

    a_hold_stalled: assert property (@(posedge clk) disable iff (rst)
        (result_valid && !result_ready) |=> (result_valid && $stable(result)));

endmodule

`default_nettype wire

//--- design/int_prf.sv
`default_nettype none

`include "int_rs_defs.svh"

module int_prf (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [`PHYS_IDX-1:0] rs1_phy,
    input  logic [`PHYS_IDX-1:0] rs2_phy,
    output logic [`XLEN-1:0]     rs1_value,
    output logic [`XLEN-1:0]     rs2_value,
    input  logic                 wr_en,
    input  logic [`PHYS_IDX-1:0] wr_phy,
    input  logic [`XLEN-1:0]     wr_value
);

    logic [`XLEN-1:0] regs [`PHYS_REGS];

    // p0 is never written so it keeps its reset zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PHYS_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_phy != '0)) begin
            regs[wr_phy] <= wr_value;
        end
    end

    // combinational read, old value on the write edge
    assign rs1_value = regs[rs1_phy];
    assign rs2_value = regs[rs2_phy];

endmodule

`default_nettype wire

//--- design/int_rs_ordered.sv
`default_nettype none

`include "int_rs_defs.svh"

module int_rs_ordered
    import uop_pkg::*;
    import rs_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 dispatch_valid,
    input  dispatch_uop_t        dispatch_uop,
    output logic                 dispatch_ready,
    output logic                 issue_valid,
    output fu_alu_req_t          issue_req,
    input  logic                 alu_ready,
    input  logic                 cdb_valid,
    input  cdb_t                 cdb,
    output logic [`PHYS_IDX-1:0] rs1_phy,
    output logic [`PHYS_IDX-1:0] rs2_phy,
    input  logic [`XLEN-1:0]     rs1_value,
    input  logic [`XLEN-1:0]     rs2_value
);

    localparam int DEPTH = `INTRS_DEPTH;

    typedef logic [`INTRS_IDX-1:0] slot_idx_t;
    typedef logic [`INTRS_IDX:0]   slot_cnt_t;

    logic [DEPTH-1:0] slot_valid;
    logic [DEPTH-1:0] slot_request;
    int_rs_entry_t    slot_entry [DEPTH];
    int_rs_entry_t    dispatch_entry;
    int_rs_entry_t    issued_entry;
    slot_idx_t        issue_idx;
    slot_cnt_t        top;
    slot_cnt_t        top_popped;
    slot_cnt_t        top_next;
    logic             push_en;
    logic             pop_en;

    always_comb begin
        dispatch_entry.rob_id    = dispatch_uop.rob_id;
        dispatch_entry.rs1_phy   = dispatch_uop.rs1_phy;
        dispatch_entry.rs1_valid = dispatch_uop.rs1_valid;
        dispatch_entry.rs2_phy   = dispatch_uop.rs2_phy;
        dispatch_entry.rs2_valid = dispatch_uop.rs2_valid;
        dispatch_entry.rd_phy    = dispatch_uop.rd_phy;
        dispatch_entry.op2_sel   = dispatch_uop.op2_sel;
        dispatch_entry.imm       = dispatch_uop.imm;
        dispatch_entry.fu_opcode = dispatch_uop.fu_opcode;
    end

    ////////////////////
    // push and pop
    ////////////////////

    assign dispatch_ready = ~&slot_valid;
    assign push_en        = dispatch_valid && dispatch_ready;
    assign pop_en         = issue_valid && alu_ready;

    // pop frees a slot first and the push lands on the new top
    assign top_popped = pop_en ? top - 1'b1 : top;
    assign top_next   = push_en ? top_popped + 1'b1 : top_popped;

    always_ff @(posedge clk) begin
        if (rst) begin
            top <= '0;
        end else begin
            top <= top_next;
        end
    end

    ////////////////////
    // slot array
    ////////////////////

    for (genvar i = 0; i < DEPTH; i++) begin : g_slot
        rs_update_sel_t update_sel;
        logic           above_valid;
        int_rs_entry_t  above_entry;
        logic           load;
        int_rs_entry_t  load_entry;
        logic           grant;
        logic           clear;

        if (i < DEPTH - 1) begin : g_above
            assign above_valid = slot_valid[i+1];
            assign above_entry = slot_entry[i+1];
        end else begin : g_last
            // nothing sits above the last slot
            assign above_valid = 1'b0;
            assign above_entry = '0;
        end

        // push wins over shift at the post-pop top
        assign update_sel = (push_en && (slot_cnt_t'(i) == top_popped)) ? upd_push_in :
                            (pop_en && (slot_idx_t'(i) >= issue_idx))   ? upd_next    :
                                                                          upd_self;

        always_comb begin
            load       = 1'b0;
            load_entry = above_entry;
            case (update_sel)
                upd_next: begin
                    load = above_valid;
                end
                upd_push_in: begin
                    load       = 1'b1;
                    load_entry = dispatch_entry;
                end
                default: begin
                    load = 1'b0;
                end
            endcase
        end

        // the issued slot leaves and everything above it moves down
        assign grant = pop_en && (slot_idx_t'(i) == issue_idx);
        assign clear = pop_en && (slot_idx_t'(i) > issue_idx);

        rs_entry #(
            .RS_ENTRY_T (int_rs_entry_t)
        ) u_rs_entry (
            .clk       (clk),
            .rst       (rst),
            .push_en   (load),
            .clear     (clear),
            .entry_in  (load_entry),
            .grant     (grant),
            .cdb_valid (cdb_valid),
            .cdb       (cdb),
            .valid     (slot_valid[i]),
            .request   (slot_request[i]),
            .entry     (slot_entry[i])
        );
    end

    ////////////////////
    // issue select
    ////////////////////

    // lowest index is the oldest
    always_comb begin
        issue_idx = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (slot_request[i]) begin
                issue_idx = slot_idx_t'(i);
            end
        end
    end

    assign issue_valid  = |slot_request;
    assign issued_entry = slot_entry[issue_idx];
    assign rs1_phy      = issued_entry.rs1_phy;
    assign rs2_phy      = issued_entry.rs2_phy;

    always_comb begin
        issue_req.rob_id    = issued_entry.rob_id;
        issue_req.rd_phy    = issued_entry.rd_phy;
        issue_req.op2_sel   = issued_entry.op2_sel;
        issue_req.fu_opcode = issued_entry.fu_opcode;
        issue_req.imm       = issued_entry.imm;
        issue_req.rs1_value = rs1_value;
        issue_req.rs2_value = rs2_value;
    end

    // top pointer and slot valid bits must agree on fullness
    a_no_push_full: assert property (@(posedge clk) disable iff (rst)
        (top == slot_cnt_t'(DEPTH)) |-> !push_en);

    a_top_bound: assert property (@(posedge clk) disable iff (rst)
        top <= slot_cnt_t'(DEPTH));

endmodule

`default_nettype wire

//--- design/rs_entry.sv
`default_nettype none

`include "int_rs_defs.svh"

module rs_entry
    import rs_pkg::*;
#(
    parameter type RS_ENTRY_T = int_rs_entry_t
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      push_en,
    input  logic      clear,
    input  RS_ENTRY_T entry_in,
    input  logic      grant,
    input  logic      cdb_valid,
    input  cdb_t      cdb,
    output logic      valid,
    output logic      request,
    output RS_ENTRY_T entry
);

    RS_ENTRY_T held_woken;
    RS_ENTRY_T in_woken;

    // wakeup applies to the held payload and to whatever is loaded this edge
    always_comb begin
        held_woken = entry;
        in_woken   = entry_in;
        held_woken.rs1_valid = entry.rs1_valid || (cdb_valid && (entry.rs1_phy == cdb.rd_phy));
        held_woken.rs2_valid = entry.rs2_valid || (cdb_valid && (entry.rs2_phy == cdb.rd_phy));
        in_woken.rs1_valid = entry_in.rs1_valid || (cdb_valid && (entry_in.rs1_phy == cdb.rd_phy));
        in_woken.rs2_valid = entry_in.rs2_valid || (cdb_valid && (entry_in.rs2_phy == cdb.rd_phy));
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else if (push_en) begin
            valid <= 1'b1;
        end else if (clear || grant) begin
            valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        entry <= push_en ? in_woken : held_woken;
    end

    assign request = valid && entry.rs1_valid && entry.rs2_valid;

    // an occupied slot is only overwritten while its contents move out
    a_push_on_busy: assert property (@(posedge clk) disable iff (rst)
        (push_en && valid) |-> (clear || grant));

endmodule

`default_nettype wire

//--- design/rs_pkg.sv
`default_nettype none

`include "int_rs_defs.svh"

package rs_pkg;

    import uop_pkg::*;

    // payload held in one station slot
    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHYS_IDX-1:0] rs1_phy;
        logic                 rs1_valid;
        logic [`PHYS_IDX-1:0] rs2_phy;
        logic                 rs2_valid;
        logic [`PHYS_IDX-1:0] rd_phy;
        op2_sel_t             op2_sel;
        logic [`XLEN-1:0]     imm;
        fu_op_t               fu_opcode;
    } int_rs_entry_t;

    // issued op with its operands already read
    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHYS_IDX-1:0] rd_phy;
        op2_sel_t             op2_sel;
        fu_op_t               fu_opcode;
        logic [`XLEN-1:0]     imm;
        logic [`XLEN-1:0]     rs1_value;
        logic [`XLEN-1:0]     rs2_value;
    } fu_alu_req_t;

    // common data bus broadcast
    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHYS_IDX-1:0] rd_phy;
        logic [`XLEN-1:0]     value;
    } cdb_t;

    // next-state source of a slot
    typedef enum logic [1:0] {
        upd_self    = 2'd0,
        upd_next    = 2'd1,
        upd_push_in = 2'd2
    } rs_update_sel_t;

endpackage

`default_nettype wire

//--- design/uop_pkg.sv
`default_nettype none

`include "int_rs_defs.svh"

package uop_pkg;

    // alu operation codes
    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_or  = 3'd3,
        op_xor = 3'd4,
        op_sll = 3'd5,
        op_slt = 3'd6
    } fu_op_t;

    // source of the second alu operand
    typedef enum logic {
        op2_reg = 1'b0,
        op2_imm = 1'b1
    } op2_sel_t;

    // micro-op as handed over by dispatch
    typedef struct packed {
        logic [`ROB_IDX-1:0]  rob_id;
        logic [`PHYS_IDX-1:0] rs1_phy;
        logic                 rs1_valid;
        logic [`PHYS_IDX-1:0] rs2_phy;
        logic                 rs2_valid;
        logic [`PHYS_IDX-1:0] rd_phy;
        op2_sel_t             op2_sel;
        logic [`XLEN-1:0]     imm;
        fu_op_t               fu_opcode;
    } dispatch_uop_t;

endpackage

`default_nettype wire

//--- design/int_rs_defs.svh
`ifndef INT_RS_DEFS_SVH
`define INT_RS_DEFS_SVH

// reservation station geometry
`define INTRS_DEPTH 8
`define INTRS_IDX   3

// physical register file, p0 reads zero and drops writes
`define PHYS_REGS   32
`define PHYS_IDX    5

// reorder buffer tag width
`define ROB_IDX     4

// datapath width
`define XLEN        32

`endif
